// ==== logic/xt_periph_pkg.sv ====
// Shared types and constants for the XT peripheral bus glue.
// Every block refers to these by scoped name through xt_periph_pkg.
package xt_periph_pkg;

    // I/O and memory decode constants
    localparam logic [15:0] EMS_PORT_BASE   = 16'h0260;
    localparam logic [15:0] LPT_DATA_PORT   = 16'h0378;
    localparam logic [15:0] LPT_STATUS_PORT = 16'h0379;
    localparam logic [7:0]  EMS_DISABLE_CODE = 8'hFF;

    // Segment prefix of the EMS frame, indexed by ems_address (A000h, C000h, D000h)
    localparam logic [2:0][3:0] PAGE_WINDOW_BASE = {4'hD, 4'hC, 4'hA};

    localparam logic [4:0] CGA_REGION   = 5'b10111;
    localparam logic [4:0] MDA_REGION   = 5'b10110;
    localparam logic [3:0] BIOS_REGION  = 4'b1111;
    localparam logic [5:0] XTIDE_REGION = 6'b111011;

    localparam int         EMS_PAGES       = 4;
    localparam logic [7:0] LPT_RESET_VALUE = 8'hFF;

    // One CPU bus cycle as seen by the chipset
    typedef struct packed {
        logic [19:0] address;
        logic [7:0]  data;
        logic        io_read_n;
        logic        io_write_n;
        logic        memory_read_n;
        logic        memory_write_n;
        logic        address_enable_n;
    } cpu_bus_t;

    // Chipset slots are active low, glue selects active high
    typedef struct packed {
        logic dma_n;
        logic pic_n;
        logic pit_n;
        logic ppi_n;
        logic dma_page_n;
        logic ems;
        logic lpt_data;
        logic lpt_status;
    } io_select_t;

    typedef struct packed {
        logic cga_n;
        logic mda_n;
        logic bios_n;
        logic xtide_n;
    } mem_select_t;

    // Read bytes from the external 8259, 8253 and 8255
    typedef struct packed {
        logic [7:0] pic;
        logic [7:0] pit;
        logic [7:0] ppi;
    } chip_read_t;

    typedef struct packed {
        logic [7:0] data;
        logic       io;
    } port_b_t;

    // EMS register write, either a command code or a page number
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic       high;
            logic [6:0] page;
        } fields;
    } ems_write_u;

endpackage

// ==== logic/io_address_decoder.sv ====
// Decodes CPU I/O and memory cycles into chip selects.
// Purely combinational; selects follow the bus within the same cycle.
`timescale 1ns/1ps

module io_address_decoder (
    input  xt_periph_pkg::cpu_bus_t    bus_i,
    input  logic                       ems_enabled_i,
    input  logic                       enable_cga_i,
    input  logic                       enable_mda_i,
    output xt_periph_pkg::io_select_t  io_select_o,
    output xt_periph_pkg::mem_select_t mem_select_o
);

    logic       iorq;
    logic       io_cycle;
    logic       mem_cycle;
    logic [7:0] slot_hit;

    assign iorq      = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign io_cycle  = iorq & ~bus_i.address_enable_n;
    assign mem_cycle = ~iorq & ~bus_i.address_enable_n;

    // Eight 32-port slots in the 000h-0FFh range
    always_comb begin
        slot_hit = 8'h00;
        if (~bus_i.address_enable_n & ~bus_i.address[9] & ~bus_i.address[8]) begin
            slot_hit[bus_i.address[7:5]] = 1'b1;
        end
    end

    always_comb begin
        io_select_o.dma_n      = ~(iorq & slot_hit[0]);
        io_select_o.pic_n      = ~(iorq & slot_hit[1]);
        io_select_o.pit_n      = ~(iorq & slot_hit[2]);
        io_select_o.ppi_n      = ~(iorq & slot_hit[3]);
        io_select_o.dma_page_n = ~(iorq & slot_hit[4]);

        // EMS map ports 260h-263h
        io_select_o.ems = io_cycle & ems_enabled_i &
            (bus_i.address[15:2] == xt_periph_pkg::EMS_PORT_BASE[15:2]);

        io_select_o.lpt_data   = io_cycle &
            (bus_i.address[15:0] == xt_periph_pkg::LPT_DATA_PORT);
        io_select_o.lpt_status = io_cycle &
            (bus_i.address[15:0] == xt_periph_pkg::LPT_STATUS_PORT);
    end

    always_comb begin
        // B8000h-BFFFFh
        mem_select_o.cga_n   = ~(mem_cycle & enable_cga_i &
            (bus_i.address[19:15] == xt_periph_pkg::CGA_REGION));
        // B0000h-B7FFFh
        mem_select_o.mda_n   = ~(mem_cycle & enable_mda_i &
            (bus_i.address[19:15] == xt_periph_pkg::MDA_REGION));
        // F0000h-FFFFFh
        mem_select_o.bios_n  = ~(mem_cycle &
            (bus_i.address[19:16] == xt_periph_pkg::BIOS_REGION));
        // EC000h-EFFFFh
        mem_select_o.xtide_n = ~(mem_cycle &
            (bus_i.address[19:14] == xt_periph_pkg::XTIDE_REGION));
    end

endmodule

// ==== logic/ems_page_mapper.sv ====
// EMS page-map registers with readback and frame window hit flags.
// Writes land on the clock edge; readback and hits show them the cycle after.
`timescale 1ns/1ps

module ems_page_mapper (
    input  logic                                 clock,
    input  logic                                 reset,
    input  xt_periph_pkg::cpu_bus_t              bus_i,
    input  logic                                 ems_select_i,
    input  logic [1:0]                           ems_address_i,
    output logic [7:0]                           readback_o,
    output logic [xt_periph_pkg::EMS_PAGES-1:0]  ems_hit_o
);

    xt_periph_pkg::ems_write_u             write_byte;
    logic [6:0]                            map_page [xt_periph_pkg::EMS_PAGES];
    logic [xt_periph_pkg::EMS_PAGES-1:0]   map_enable;
    logic [1:0]                            reg_index;
    logic [3:0]                            window_base;
    logic                                  iorq;

    assign write_byte.raw = bus_i.data;
    assign reg_index      = bus_i.address[1:0];
    assign iorq           = ~bus_i.io_read_n | ~bus_i.io_write_n;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < xt_periph_pkg::EMS_PAGES; i++) begin
                map_page[i] <= 7'h00;
            end
            map_enable <= '0;
        end else if (ems_select_i & ~bus_i.io_write_n) begin
            if (write_byte.raw == xt_periph_pkg::EMS_DISABLE_CODE) begin
                map_page[reg_index]   <= 7'h7F;
                map_enable[reg_index] <= 1'b0;
            end else if (~write_byte.fields.high) begin
                map_page[reg_index]   <= write_byte.fields.page;
                map_enable[reg_index] <= 1'b1;
            end
            // 80h-FEh leave the register alone
        end
    end

    assign readback_o = map_enable[reg_index] ? {1'b0, map_page[reg_index]} : 8'hFF;

    // Segment 11b shares the D000h frame with 10b
    always_comb begin
        case (ems_address_i)
            2'd0:    window_base = xt_periph_pkg::PAGE_WINDOW_BASE[0];
            2'd1:    window_base = xt_periph_pkg::PAGE_WINDOW_BASE[1];
            default: window_base = xt_periph_pkg::PAGE_WINDOW_BASE[2];
        endcase
    end

    // One 16 KB window per map register
    always_comb begin
        for (int n = 0; n < xt_periph_pkg::EMS_PAGES; n++) begin
            ems_hit_o[n] = ~iorq & map_enable[n] &
                (bus_i.address[19:14] == {window_base, 2'(n)});
        end
    end

endmodule

// ==== logic/keyboard_glue.sv ====
// Keyboard side of the PPI: synchronises scancode and IRQ into port A,
// turns a rising reset bit on port B into a send request and drives
// the PS/2 clock inhibit.
`timescale 1ns/1ps

module keyboard_glue (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [7:0]             keycode_i,
    input  logic                   kbd_irq_i,
    input  xt_periph_pkg::port_b_t port_b_i,
    input  logic                   ps2_send_clock_i,
    output logic [7:0]             port_a_o,
    output logic                   kbd_interrupt_o,
    output logic                   send_request_o,
    output logic                   ps2_clock_o
);

    logic [7:0] keycode_ff;
    logic       irq_ff;
    logic       reset_bit;
    logic       prev_reset_bit;

    // Port B bit 6 low holds the keyboard in reset
    assign reset_bit = port_b_i.data[6];

    // Two stages for scancode and IRQ
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            keycode_ff      <= 8'h00;
            port_a_o        <= 8'h00;
            irq_ff          <= 1'b0;
            kbd_interrupt_o <= 1'b0;
        end else begin
            keycode_ff      <= keycode_i;
            port_a_o        <= keycode_ff;
            irq_ff          <= kbd_irq_i;
            kbd_interrupt_o <= irq_ff;
        end
    end

    // Release from reset asks the keyboard for a self test
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            prev_reset_bit <= 1'b0;
            send_request_o <= 1'b0;
        end else begin
            prev_reset_bit <= reset_bit;
            send_request_o <= reset_bit & ~prev_reset_bit;
        end
    end

    // Clock held low while a code is pending, while sending, or in reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ps2_clock_o <= 1'b1;
        end else begin
            ps2_clock_o <= ~(kbd_irq_i | ~ps2_send_clock_i | ~reset_bit);
        end
    end

endmodule

// ==== logic/sound_port.sv ====
// LPT data latch feeding the Covox/DSS DAC, plus PC speaker gating.
// The latch is also read back through the LPT data port.
`timescale 1ns/1ps

module sound_port (
    input  logic                    clock,
    input  logic                    reset,
    input  xt_periph_pkg::cpu_bus_t bus_i,
    input  logic                    lpt_select_i,
    input  logic                    dss_covox_en_i,
    input  xt_periph_pkg::port_b_t  port_b_i,
    input  logic                    pit_out2_i,
    output logic [7:0]              dac_data_o,
    output logic                    dac_write_o,
    output logic                    speaker_o,
    output logic                    timer2_gate_o
);

    logic lpt_write;
    logic port_b_driven;

    assign lpt_write = lpt_select_i & ~bus_i.io_write_n;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dac_data_o <= xt_periph_pkg::LPT_RESET_VALUE;
        end else if (lpt_write) begin
            dac_data_o <= bus_i.data;
        end
    end

    // DAC only sees writes when the Covox is switched in
    assign dac_write_o = dss_covox_en_i & lpt_write;

    // Speaker controls only count while port B is an output
    assign port_b_driven = ~port_b_i.io;
    assign speaker_o     = pit_out2_i & port_b_i.data[1] & port_b_driven;
    assign timer2_gate_o = port_b_i.data[0] & port_b_driven;

endmodule

// ==== logic/read_data_mux.sv ====
// Picks the byte the chipset drives onto the CPU data bus.
// Fixed priority; INTA always wins so the vector reaches the CPU.
`timescale 1ns/1ps

module read_data_mux (
    input  xt_periph_pkg::cpu_bus_t   bus_i,
    input  logic                      interrupt_acknowledge_n_i,
    input  xt_periph_pkg::io_select_t io_select_i,
    input  xt_periph_pkg::chip_read_t chip_read_i,
    input  logic [7:0]                ems_readback_i,
    input  logic [7:0]                lpt_data_i,
    input  logic                      dss_full_i,
    output logic [7:0]                data_bus_o,
    output logic                      data_from_chipset_o
);

    logic io_read;

    assign io_read = ~bus_i.io_read_n;

    always_comb begin
        data_from_chipset_o = 1'b1;
        if (~interrupt_acknowledge_n_i) begin
            data_bus_o = chip_read_i.pic;
        end else if (~io_select_i.pic_n & io_read) begin
            data_bus_o = chip_read_i.pic;
        end else if (~io_select_i.pit_n & io_read) begin
            data_bus_o = chip_read_i.pit;
        end else if (~io_select_i.ppi_n & io_read) begin
            data_bus_o = chip_read_i.ppi;
        end else if (io_select_i.ems & io_read) begin
            data_bus_o = ems_readback_i;
        end else if (io_select_i.lpt_data & io_read) begin
            data_bus_o = lpt_data_i;
        end else if (io_select_i.lpt_status & io_read) begin
            // Only the DSS FIFO full flag is implemented
            data_bus_o = {1'b0, dss_full_i, 6'b000000};
        end else begin
            data_from_chipset_o = 1'b0;
            data_bus_o          = 8'h00;
        end
    end

endmodule

// ==== logic/xt_peripherals.sv ====
// Top of the XT peripheral bus glue. Wires the decoder, EMS mapper,
// keyboard glue, sound port and read mux together; PIC, PIT and PPI
// live outside and are reached through the selects and chip_read_i.
`timescale 1ns/1ps

module xt_peripherals (
    input  logic                                clock,
    input  logic                                reset,
    input  xt_periph_pkg::cpu_bus_t             bus_i,
    input  logic                                interrupt_acknowledge_n_i,
    input  xt_periph_pkg::chip_read_t           chip_read_i,
    input  xt_periph_pkg::port_b_t              port_b_i,
    input  logic                                pit_out2_i,
    input  logic [7:0]                          keycode_i,
    input  logic                                kbd_irq_i,
    input  logic                                ps2_send_clock_i,
    input  logic                                ems_enabled_i,
    input  logic [1:0]                          ems_address_i,
    input  logic                                enable_cga_i,
    input  logic                                enable_mda_i,
    input  logic                                dss_covox_en_i,
    input  logic                                dss_full_i,
    output xt_periph_pkg::io_select_t           io_select_o,
    output xt_periph_pkg::mem_select_t          mem_select_o,
    output logic [xt_periph_pkg::EMS_PAGES-1:0] ems_hit_o,
    output logic [7:0]                          data_bus_o,
    output logic                                data_from_chipset_o,
    output logic [7:0]                          port_a_o,
    output logic                                kbd_interrupt_o,
    output logic                                send_request_o,
    output logic                                ps2_clock_o,
    output logic                                speaker_o,
    output logic                                timer2_gate_o,
    output logic [7:0]                          dac_data_o,
    output logic                                dac_write_o
);

    logic [7:0] ems_readback;

    io_address_decoder decoder_inst (
        .bus_i         (bus_i),
        .ems_enabled_i (ems_enabled_i),
        .enable_cga_i  (enable_cga_i),
        .enable_mda_i  (enable_mda_i),
        .io_select_o   (io_select_o),
        .mem_select_o  (mem_select_o)
    );

    ems_page_mapper ems_inst (
        .clock         (clock),
        .reset         (reset),
        .bus_i         (bus_i),
        .ems_select_i  (io_select_o.ems),
        .ems_address_i (ems_address_i),
        .readback_o    (ems_readback),
        .ems_hit_o     (ems_hit_o)
    );

    keyboard_glue keyboard_inst (
        .clock            (clock),
        .reset            (reset),
        .keycode_i        (keycode_i),
        .kbd_irq_i        (kbd_irq_i),
        .port_b_i         (port_b_i),
        .ps2_send_clock_i (ps2_send_clock_i),
        .port_a_o         (port_a_o),
        .kbd_interrupt_o  (kbd_interrupt_o),
        .send_request_o   (send_request_o),
        .ps2_clock_o      (ps2_clock_o)
    );

    // DAC latch doubles as the LPT data readback
    sound_port sound_inst (
        .clock          (clock),
        .reset          (reset),
        .bus_i          (bus_i),
        .lpt_select_i   (io_select_o.lpt_data),
        .dss_covox_en_i (dss_covox_en_i),
        .port_b_i       (port_b_i),
        .pit_out2_i     (pit_out2_i),
        .dac_data_o     (dac_data_o),
        .dac_write_o    (dac_write_o),
        .speaker_o      (speaker_o),
        .timer2_gate_o  (timer2_gate_o)
    );

    read_data_mux mux_inst (
        .bus_i                     (bus_i),
        .interrupt_acknowledge_n_i (interrupt_acknowledge_n_i),
        .io_select_i               (io_select_o),
        .chip_read_i               (chip_read_i),
        .ems_readback_i            (ems_readback),
        .lpt_data_i                (dac_data_o),
        .dss_full_i                (dss_full_i),
        .data_bus_o                (data_bus_o),
        .data_from_chipset_o       (data_from_chipset_o)
    );

endmodule

// ==== tb/tb_xt_peripherals.sv ====
// Testbench for the XT peripheral bus glue. Drives random and directed bus,
// port-B and keyboard stimulus; concurrent assertions compare every output
// with reference rules kept in this file.
`timescale 1ns/1ps

module tb_xt_peripherals;

    localparam int CLOCK_PERIOD      = 4;
    localparam int TEST_COUNT        = 5;
    localparam int TEST_CYCLE_BUDGET = 500;
    localparam int CYCLE_IDLE        = 0;
    localparam int CYCLE_IO_READ     = 1;
    localparam int CYCLE_IO_WRITE    = 2;
    localparam int CYCLE_MEM_READ    = 3;
    localparam int CYCLE_MEM_WRITE   = 4;

    logic                       clock = 1'b0;
    logic                       reset;
    xt_periph_pkg::cpu_bus_t    bus_i;
    xt_periph_pkg::chip_read_t  chip_read_i;
    xt_periph_pkg::port_b_t     port_b_i;
    logic [7:0]                 keycode_i;
    logic [1:0]                 ems_address_i;
    logic interrupt_acknowledge_n_i, pit_out2_i, kbd_irq_i, ps2_send_clock_i;
    logic ems_enabled_i, enable_cga_i, enable_mda_i, dss_covox_en_i, dss_full_i;
    logic dma_cycle;

    xt_periph_pkg::io_select_t  io_select_o, exp_io;
    xt_periph_pkg::mem_select_t mem_select_o, exp_mem;
    logic [3:0] ems_hit_o, exp_hit;
    logic [7:0] data_bus_o, port_a_o, dac_data_o;
    logic data_from_chipset_o, kbd_interrupt_o, send_request_o, ps2_clock_o;
    logic speaker_o, timer2_gate_o, dac_write_o;

    // Reference state and expected values
    logic [6:0]  model_page [4];
    logic [3:0]  model_en;
    logic [7:0]  lpt_model, key_d1, key_d2, readback;
    logic        irq_d1, irq_d2, prev_b6, exp_send, exp_ps2;
    logic        iorq, io_cycle, mem_cycle;
    logic [15:0] port;
    logic [19:0] frame_offset, address;
    logic [8:0]  exp_bus;
    logic [10:0] exp_sound, exp_kbd;

    logic [31:0] rng_state = 32'hea83;
    logic [31:0] r, a;
    string       test_name;
    int          error_count = 0;
    int          test_errors = 0;
    int          tests_failing = 0;

    xt_peripherals xt_peripherals_inst (.*);

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    always_comb begin
        iorq      = !bus_i.io_read_n || !bus_i.io_write_n;
        io_cycle  = iorq && !bus_i.address_enable_n;
        mem_cycle = !iorq && !bus_i.address_enable_n;
        port      = bus_i.address[15:0];
        // Only A9..A5 matter for the eight chipset slots
        exp_io.dma_n      = !(io_cycle && bus_i.address[9:5] == 5'd0);
        exp_io.pic_n      = !(io_cycle && bus_i.address[9:5] == 5'd1);
        exp_io.pit_n      = !(io_cycle && bus_i.address[9:5] == 5'd2);
        exp_io.ppi_n      = !(io_cycle && bus_i.address[9:5] == 5'd3);
        exp_io.dma_page_n = !(io_cycle && bus_i.address[9:5] == 5'd4);
        exp_io.ems        = io_cycle && ems_enabled_i && port >= 16'h0260 && port <= 16'h0263;
        exp_io.lpt_data   = io_cycle && port == 16'h0378;
        exp_io.lpt_status = io_cycle && port == 16'h0379;
        exp_mem.cga_n   = !(mem_cycle && enable_cga_i && bus_i.address >= 20'hB8000 &&
            bus_i.address <= 20'hBFFFF);
        exp_mem.mda_n   = !(mem_cycle && enable_mda_i && bus_i.address >= 20'hB0000 &&
            bus_i.address <= 20'hB7FFF);
        exp_mem.bios_n  = !(mem_cycle && bus_i.address >= 20'hF0000);
        exp_mem.xtide_n = !(mem_cycle && bus_i.address >= 20'hEC000 &&
            bus_i.address <= 20'hEFFFF);
        case (ems_address_i)
            2'd0:    frame_offset = bus_i.address - 20'hA0000;
            2'd1:    frame_offset = bus_i.address - 20'hC0000;
            default: frame_offset = bus_i.address - 20'hD0000;
        endcase
        // Four 16 KB windows inside the 64 KB frame
        for (int n = 0; n < 4; n++) begin
            exp_hit[n] = !iorq && model_en[n] && frame_offset[19:16] == 4'h0 &&
                frame_offset[15:14] == 2'(n);
        end
        readback = model_en[bus_i.address[1:0]] ? {1'b0, model_page[bus_i.address[1:0]]}
            : 8'hFF;
        if (!interrupt_acknowledge_n_i) begin
            exp_bus = {1'b1, chip_read_i.pic};
        end else if (!bus_i.io_read_n && !exp_io.pic_n) begin
            exp_bus = {1'b1, chip_read_i.pic};
        end else if (!bus_i.io_read_n && !exp_io.pit_n) begin
            exp_bus = {1'b1, chip_read_i.pit};
        end else if (!bus_i.io_read_n && !exp_io.ppi_n) begin
            exp_bus = {1'b1, chip_read_i.ppi};
        end else if (!bus_i.io_read_n && exp_io.ems) begin
            exp_bus = {1'b1, readback};
        end else if (!bus_i.io_read_n && exp_io.lpt_data) begin
            exp_bus = {1'b1, lpt_model};
        end else if (!bus_i.io_read_n && exp_io.lpt_status) begin
            exp_bus = {2'b10, dss_full_i, 6'd0};
        end else begin
            exp_bus = 9'h000;
        end
        exp_sound = {lpt_model, dss_covox_en_i && exp_io.lpt_data && !bus_i.io_write_n,
            pit_out2_i && port_b_i.data[1] && !port_b_i.io, port_b_i.data[0] && !port_b_i.io};
        exp_kbd = {key_d2, irq_d2, exp_send, exp_ps2};
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                model_page[i] <= 7'h00;
            end
            model_en  <= 4'h0;
            lpt_model <= 8'hFF;
            {key_d1, key_d2, irq_d1, irq_d2, prev_b6, exp_send} <= '0;
            exp_ps2   <= 1'b1;
        end else begin
            if (exp_io.ems && !bus_i.io_write_n && bus_i.data == 8'hFF) begin
                model_page[bus_i.address[1:0]] <= 7'h7F;
                model_en[bus_i.address[1:0]]   <= 1'b0;
            end else if (exp_io.ems && !bus_i.io_write_n && bus_i.data < 8'h80) begin
                model_page[bus_i.address[1:0]] <= bus_i.data[6:0];
                model_en[bus_i.address[1:0]]   <= 1'b1;
            end
            if (exp_io.lpt_data && !bus_i.io_write_n) begin
                lpt_model <= bus_i.data;
            end
            key_d1   <= keycode_i;
            key_d2   <= key_d1;
            irq_d1   <= kbd_irq_i;
            irq_d2   <= irq_d1;
            prev_b6  <= port_b_i.data[6];
            exp_send <= port_b_i.data[6] && !prev_b6;
            exp_ps2  <= !kbd_irq_i && ps2_send_clock_i && port_b_i.data[6];
        end
    end

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        test_errors++;
        $display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
    endtask

    assert property (@(posedge clock) disable iff (reset)
        {io_select_o, mem_select_o, ems_hit_o} == {exp_io, exp_mem, exp_hit})
        else report_mismatch("selects", 32'($sampled({exp_io, exp_mem, exp_hit})),
            32'($sampled({io_select_o, mem_select_o, ems_hit_o})));
    assert property (@(posedge clock) disable iff (reset)
        {data_from_chipset_o, data_bus_o} == exp_bus)
        else report_mismatch("data bus", 32'($sampled(exp_bus)),
            32'($sampled({data_from_chipset_o, data_bus_o})));
    assert property (@(posedge clock) disable iff (reset)
        {dac_data_o, dac_write_o, speaker_o, timer2_gate_o} == exp_sound)
        else report_mismatch("sound", 32'($sampled(exp_sound)),
            32'($sampled({dac_data_o, dac_write_o, speaker_o, timer2_gate_o})));
    assert property (@(posedge clock) disable iff (reset)
        {port_a_o, kbd_interrupt_o, send_request_o, ps2_clock_o} == exp_kbd)
        else report_mismatch("keyboard", 32'($sampled(exp_kbd)),
            32'($sampled({port_a_o, kbd_interrupt_o, send_request_o, ps2_clock_o})));

    // Called at a falling edge; holds the cycle across one rising edge
    task automatic run_cycle(input logic [19:0] addr, input logic [7:0] data, input int kind);
        bus_i.address          = addr;
        bus_i.data             = data;
        bus_i.io_read_n        = (kind != CYCLE_IO_READ);
        bus_i.io_write_n       = (kind != CYCLE_IO_WRITE);
        bus_i.memory_read_n    = (kind != CYCLE_MEM_READ);
        bus_i.memory_write_n   = (kind != CYCLE_MEM_WRITE);
        bus_i.address_enable_n = (kind == CYCLE_IDLE) || dma_cycle;
        @(negedge clock);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failing++;
            $display("test %s: %0d mismatches", test_name, test_errors);
        end
    endtask

    initial begin
        #(CLOCK_PERIOD * (TEST_COUNT * TEST_CYCLE_BUDGET + 100));
        $display("Watchdog: tests did not finish within %0d ns", $time);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        bus_i = {20'h00000, 8'h00, 5'b11111};
        chip_read_i = '0;
        port_b_i = '0;
        keycode_i = 8'h00;
        ems_address_i = 2'd0;
        {interrupt_acknowledge_n_i, ps2_send_clock_i} = 2'b11;
        {pit_out2_i, kbd_irq_i, ems_enabled_i, enable_cga_i, enable_mda_i} = '0;
        {dss_covox_en_i, dss_full_i, dma_cycle} = '0;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        start_test("decode");
        for (int i = 0; i < 400; i++) begin
            r = next_random();
            a = next_random();
            {enable_mda_i, enable_cga_i, ems_enabled_i} = r[2:0];
            dma_cycle = (r[5:3] == 3'd0);
            case (r[7:6])
                2'd0:    address = {4'h0, a[15:10], 2'b00, a[7:0]};
                2'd1:    address = {4'h0, 14'h0098, a[1:0]};
                2'd2:    address = {4'h0, 15'h01BC, a[0]};
                // Segments A, B, E and F hold the memory regions
                default: address = {1'b1, a[18], 1'b1, a[16:0]};
            endcase
            run_cycle(address, a[31:24], (r[7:6] == 2'd3) ?
                (r[8] ? CYCLE_MEM_READ : CYCLE_MEM_WRITE) : int'(r[10:8]) % 5);
        end
        dma_cycle = 1'b0;
        end_test();

        start_test("ems_map");
        ems_enabled_i = 1'b1;
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            address = {4'h0, 16'h0260 + 16'(i)};
            run_cycle(address, {1'b0, r[6:0]}, CYCLE_IO_WRITE);
            run_cycle(address, 8'h00, CYCLE_IO_READ);
            // 80h-FEh must not disturb the page just written
            run_cycle(address, (r[14:8] == 7'h7F) ? 8'hFE : {1'b1, r[14:8]}, CYCLE_IO_WRITE);
            run_cycle(address, 8'h00, CYCLE_IO_READ);
            run_cycle(address, 8'hFF, CYCLE_IO_WRITE);
            run_cycle(address, 8'h00, CYCLE_IO_READ);
            run_cycle(address, {1'b0, r[22:16]}, CYCLE_IO_WRITE);
        end
        for (int s = 0; s < 4; s++) begin
            ems_address_i = 2'(s);
            if (s == 2) begin
                run_cycle(20'h00262, 8'hFF, CYCLE_IO_WRITE);
            end
            for (int j = 0; j < 40; j++) begin
                r = next_random();
                run_cycle({4'hA + {2'b00, r[1:0]}, r[17:2]}, r[25:18],
                    r[26] ? CYCLE_MEM_WRITE : (r[27] ? CYCLE_MEM_READ : CYCLE_IO_READ));
            end
        end
        end_test();

        start_test("read_priority");
        for (int i = 0; i < 300; i++) begin
            r = next_random();
            a = next_random();
            chip_read_i = r[23:0];
            interrupt_acknowledge_n_i = (r[25:24] != 2'd0);
            {ems_enabled_i, dss_full_i} = r[27:26];
            case (a[2:0])
                3'd0:    address = {12'h000, 3'd1, a[8:4]};
                3'd1:    address = {12'h000, 3'd2, a[8:4]};
                3'd2:    address = {12'h000, 3'd3, a[8:4]};
                3'd3:    address = {4'h0, 14'h0098, a[9:8]};
                3'd4:    address = 20'h00378;
                3'd5:    address = 20'h00379;
                3'd6:    address = {12'h000, 3'd0, a[8:4]};
                default: address = {4'h0, a[31:16]};
            endcase
            run_cycle(address, a[15:8], (a[11:10] == 2'd3) ? CYCLE_IO_WRITE : CYCLE_IO_READ);
        end
        interrupt_acknowledge_n_i = 1'b1;
        end_test();

        start_test("lpt_speaker");
        run_cycle(20'h00000, 8'h00, CYCLE_IDLE);
        reset = 1'b1;
        repeat (2) @(negedge clock);
        reset = 1'b0;
        run_cycle(20'h00378, 8'h00, CYCLE_IO_READ);
        for (int i = 0; i < 8; i++) begin
            r = next_random();
            {dss_full_i, dss_covox_en_i} = r[1:0];
            run_cycle(20'h00378, r[15:8], CYCLE_IO_WRITE);
            run_cycle(20'h00378, 8'h00, CYCLE_IO_READ);
            run_cycle(20'h00379, 8'h00, CYCLE_IO_READ);
        end
        for (int i = 0; i < 32; i++) begin
            r = next_random();
            port_b_i = r[8:0];
            pit_out2_i = r[9];
            run_cycle(20'h00000, 8'h00, CYCLE_IDLE);
        end
        end_test();

        start_test("keyboard");
        port_b_i.io = 1'b0;
        for (int i = 0; i < 300; i++) begin
            r = next_random();
            keycode_i = r[7:0];
            kbd_irq_i = r[8];
            ps2_send_clock_i = (r[11:9] != 3'd0);
            if (r[14:12] == 3'd0) begin
                port_b_i.data[6] = ~port_b_i.data[6];
            end
            run_cycle(20'h00000, 8'h00, CYCLE_IDLE);
        end
        end_test();

        $display("tests run: %0d, failing: %0d, mismatches: %0d",
            TEST_COUNT, tests_failing, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
logic/xt_periph_pkg.sv
logic/io_address_decoder.sv
logic/ems_page_mapper.sv
logic/keyboard_glue.sv
logic/sound_port.sv
logic/read_data_mux.sv
logic/xt_peripherals.sv
tb/tb_xt_peripherals.sv

// ==== Makefile ====
# Verilator lint and simulation of the XT peripheral bus glue

VERILATOR ?= verilator
TB_TOP    ?= tb_xt_peripherals
FILE_LIST ?= list.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?=
FAIL_TEXT ?= TESTS FAILED

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR)

# A crashed simulator counts as a failure
sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_TEXT)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
